//--- Makefile
# Verilator build and run of the packet engine testbench

VERILATOR ?= verilator
TOP       ?= packet_engine_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/packet_engine_checker.sv
`timescale 1ns/1ns

module packet_engine_checker (
  input logic       clk,
  input logic       reset,
  input logic       ctrl_strb,
  input logic       eth_wr_go,
  input logic       eth_wr_stb,
  input logic       eth_busy,
  input logic       out_tick,
  input logic [9:0] out_eth_stream
);

  // single cycle strobes
  strb_pulse: assert property (@(posedge clk) disable iff (reset) ctrl_strb |=> !ctrl_strb)
    else $error("ctrl_strb high for more than one cycle");

  go_pulse: assert property (@(posedge clk) disable iff (reset) eth_wr_go |=> !eth_wr_go)
    else $error("eth_wr_go high for more than one cycle");

  // pixels only while a frame is being handled
  stb_busy: assert property (@(posedge clk) disable iff (reset) eth_wr_stb |-> eth_busy)
    else $error("eth_wr_stb while eth_busy is low");

  // ticks inside the frame carry a byte until the closing cycle
  valid_tick: assert property (@(posedge clk) disable iff (reset)
    (out_eth_stream[9] && out_tick && !out_eth_stream[8]) |=> !out_eth_stream[9])
    else $error("out_tick inside the output frame without a byte");

  // frame stays high through the cycle after each byte
  valid_frame: assert property (@(posedge clk) disable iff (reset)
    out_eth_stream[8] |=> out_eth_stream[9])
    else $error("output frame dropped right after a byte");

endmodule

//--- bench/packet_engine_tb.sv
`timescale 1ns/1ns

module packet_engine_tb import pkt_pkg::*; ();

  // frames sent over the whole run, sizes the watchdog
  localparam int NUM_FRAMES = 26;
  localparam int FRAME_NS   = 2000;
  localparam int IDLE_LIMIT = 2000;

  logic         clk;
  logic         reset;
  logic         out_tick;
  logic         eth_wr_done;
  logic [9:0]   in_eth_stream;
  word_t        temperature;
  word_t        v_vccint;
  word_t        v_vccaux;
  byte_t        buttons;
  logic [127:0] user_status;
  logic [9:0]   out_eth_stream;
  logic         eth_busy;
  logic         ctrl_strb;
  logic         eth_wr_go;
  logic         eth_wr_stb;
  word_t        ctrl_enables;
  word_t        img_size_x;
  word_t        img_size_y;
  coeff_t       ctrl_coeff;
  word_t        eth_wr_start_x;
  word_t        eth_wr_line;
  word_t        eth_wr_num_pixels;
  pixel_t       eth_wr_pix;
  byte_t        user_ctrl_en;
  word_t        user_ctrl;

  integer seed = 32'hc96b;
  logic   passed;
  logic   fail_shown;
  // frame being built
  byte_t  frame_buf [0:127];
  int     frame_len;
  // expected reply, left aligned, and progress through it
  logic [ACK_BITS-1:0] exp_ack;
  int     exp_ack_len;
  int     ack_idx;
  int     ack_frames;
  logic   out_frm_d;
  // expected pixel stream
  pixel_t exp_pix [0:15];
  int     exp_npix;
  int     pix_idx;
  logic   wr_armed;
  // pulse counters and their values before the frame
  int     go_cnt;
  int     strb_cnt;
  int     frames_before;
  int     strb_before;
  int     go_before;
  // register model
  word_t  m_en, m_sx, m_sy, m_wx, m_wl, m_wn, m_uctl;
  coeff_t m_coeff;
  byte_t  m_uen;

  packet_engine DUT (
    .clk               (clk),
    .reset             (reset),
    .out_tick          (out_tick),
    .eth_wr_done       (eth_wr_done),
    .in_eth_stream     (in_eth_stream),
    .temperature       (temperature),
    .v_vccint          (v_vccint),
    .v_vccaux          (v_vccaux),
    .buttons           (buttons),
    .user_status       (user_status),
    .out_eth_stream    (out_eth_stream),
    .eth_busy          (eth_busy),
    .ctrl_strb         (ctrl_strb),
    .ctrl_enables      (ctrl_enables),
    .img_size_x        (img_size_x),
    .img_size_y        (img_size_y),
    .ctrl_coeff        (ctrl_coeff),
    .eth_wr_go         (eth_wr_go),
    .eth_wr_stb        (eth_wr_stb),
    .eth_wr_start_x    (eth_wr_start_x),
    .eth_wr_line       (eth_wr_line),
    .eth_wr_num_pixels (eth_wr_num_pixels),
    .eth_wr_pix        (eth_wr_pix),
    .user_ctrl_en      (user_ctrl_en),
    .user_ctrl         (user_ctrl)
  );

  bind packet_engine packet_engine_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .ctrl_strb      (ctrl_strb),
    .eth_wr_go      (eth_wr_go),
    .eth_wr_stb     (eth_wr_stb),
    .eth_busy       (eth_busy),
    .out_tick       (out_tick),
    .out_eth_stream (out_eth_stream)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    fail_shown = 1'b1;
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_coeff(input string name, input coeff_t exp, input coeff_t act);
    if (act !== exp) abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  // reply bytes from the ack layout, status fields from the held inputs
  function automatic logic [ACK_BITS-1:0] expected_ack(input opcode_t op);
    logic [ACK_BITS-1:0] v;
    v = '0;
    v[ACK_BITS-1 -: 104] = {SERVER_MAC, MY_MAC, op};
    if (op == OP_STATUS) begin
      v[ACK_BITS-105 -: 232] = {FIRMWARE_VERSION, BOARD_TYPE, temperature, v_vccint,
                                v_vccaux, buttons, user_status};
    end
    return v;
  endfunction

  task automatic check_regs();
    check_word("ctrl_enables", m_en, ctrl_enables);
    check_word("img_size_x", m_sx, img_size_x);
    check_word("img_size_y", m_sy, img_size_y);
    check_coeff("ctrl_coeff", m_coeff, ctrl_coeff);
    check_byte("user_ctrl_en", m_uen, user_ctrl_en);
    check_word("user_ctrl", m_uctl, user_ctrl);
    check_word("eth_wr_start_x", m_wx, eth_wr_start_x);
    check_word("eth_wr_line", m_wl, eth_wr_line);
    check_word("eth_wr_num_pixels", m_wn, eth_wr_num_pixels);
  endtask

  task automatic start_frame(input mac_t dest, input opcode_t op);
    mac_t src;
    src = SERVER_MAC;
    for (int i = 0; i < 6; i++) begin
      frame_buf[i]     = dest[47 - 8*i -: 8];
      frame_buf[i + 6] = src[47 - 8*i -: 8];
    end
    frame_buf[12] = op;
    frame_len = 13;
  endtask

  task automatic add_byte(input byte_t b);
    frame_buf[frame_len] = b;
    frame_len++;
  endtask

  task automatic add_word(input word_t w);
    add_byte(w[15:8]);
    add_byte(w[7:0]);
  endtask

  // random idle gaps inside the frame, frame bit held high
  task automatic send_frame();
    int gap;
    for (int i = 0; i < frame_len; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk);
        #1 in_eth_stream = {2'b10, 8'h00};
      end
      @(posedge clk);
      #1 in_eth_stream = {2'b11, frame_buf[i]};
    end
    @(posedge clk);
    #1 in_eth_stream = '0;
  endtask

  task automatic arm_reply(input opcode_t op, input logic accepted);
    exp_ack     = expected_ack(op);
    exp_ack_len = 0;
    if (accepted) exp_ack_len = (op == OP_STATUS) ? 42 : 13;
    ack_idx       = 0;
    exp_npix      = 0;
    pix_idx       = 0;
    frames_before = ack_frames;
    strb_before   = strb_cnt;
    go_before     = go_cnt;
  endtask

  // wait for eth_busy to fall, then settle the frame's counts
  task automatic finish_frame(input int strbs, input int gos);
    int n;
    n = 0;
    @(negedge clk);
    while (eth_busy) begin
      n++;
      if (n > IDLE_LIMIT) abort_run("eth_busy did not fall after the frame");
      else @(negedge clk);
    end
    if (ack_idx != exp_ack_len) abort_run($sformatf("ack had %0d bytes, not %0d",
                                                      ack_idx, exp_ack_len));
    if (ack_frames != frames_before + ((exp_ack_len != 0) ? 1 : 0))
      abort_run("wrong number of ack frames");
    if (strb_cnt != strb_before + strbs) abort_run("wrong number of ctrl_strb pulses");
    if (go_cnt != go_before + gos) abort_run("wrong number of eth_wr_go pulses");
    if (pix_idx != exp_npix) abort_run("fewer pixel strobes than num pixels");
    check_regs();
  endtask

  task automatic run_control();
    word_t  en, sx, sy;
    coeff_t c;
    en = word_t'($random(seed));
    sx = word_t'($random(seed));
    sy = word_t'($random(seed));
    for (int i = 0; i < 13; i++) c = {c[367:0], 32'($random(seed))};
    start_frame(MY_MAC, OP_CONTROL);
    add_word(en);
    add_word(sx);
    add_word(sy);
    for (int i = 0; i < 50; i++) add_byte(c[399 - 8*i -: 8]);
    // past MAX_PAYLOAD, must not reach the coefficients
    for (int i = 0; i < 3; i++) add_byte(byte_t'($random(seed)));
    arm_reply(OP_CONTROL, 1'b1);
    send_frame();
    repeat (3) @(negedge clk);
    if (!ctrl_strb) abort_run("ctrl_strb missing two cycles after the frame ended");
    m_en    = en;
    m_sx    = sx;
    m_sy    = sy;
    m_coeff = c;
    check_regs();
    finish_frame(1, 0);
  endtask

  task automatic run_status();
    @(posedge clk);
    #1 temperature = word_t'($random(seed));
    v_vccint    = word_t'($random(seed));
    v_vccaux    = word_t'($random(seed));
    buttons     = byte_t'($random(seed));
    user_status = {$random(seed), $random(seed), $random(seed), $random(seed)};
    start_frame(MY_MAC, OP_STATUS);
    arm_reply(OP_STATUS, 1'b1);
    send_frame();
    finish_frame(0, 0);
  endtask

  task automatic run_write();
    int n;
    n    = $unsigned($random(seed)) % 16 + 1;
    m_wx = word_t'($random(seed));
    m_wl = word_t'($random(seed));
    m_wn = word_t'(n);
    start_frame(MY_MAC, OP_WRITE);
    add_word(m_wx);
    add_word(m_wl);
    add_word(m_wn);
    for (int i = 0; i < n; i++) begin
      exp_pix[i] = pixel_t'($random(seed));
      add_byte(exp_pix[i][23:16]);
      add_byte(exp_pix[i][15:8]);
      add_byte(exp_pix[i][7:0]);
    end
    arm_reply(OP_WRITE, 1'b1);
    exp_npix = n;
    wr_armed = 1'b1;
    send_frame();
    finish_frame(0, 1);
  endtask

  task automatic run_user();
    byte_t uen;
    word_t uctl;
    uen  = byte_t'($random(seed));
    uctl = word_t'($random(seed));
    start_frame(MY_MAC, OP_USER_CONTROL);
    add_byte(uen);
    add_word(uctl);
    arm_reply(OP_USER_CONTROL, 1'b1);
    send_frame();
    repeat (3) @(negedge clk);
    m_uen  = uen;
    m_uctl = uctl;
    check_byte("user_ctrl_en at load", m_uen, user_ctrl_en);
    check_word("user_ctrl at load", m_uctl, user_ctrl);
    finish_frame(0, 0);
  endtask

  // wrong destination byte, or an opcode outside the handled set
  task automatic run_drop(input logic bad_op);
    opcode_t op;
    mac_t    dest;
    int      k;
    dest = MY_MAC;
    op   = ($random(seed) & 1) ? OP_CONTROL : OP_USER_CONTROL;
    if (bad_op) begin
      op = opcode_t'($random(seed));
      while (op inside {OP_CONTROL, OP_STATUS, OP_WRITE, OP_USER_CONTROL}) op = op + 8'd1;
    end else begin
      k = $unsigned($random(seed)) % 6;
      dest[8*k +: 8] = dest[8*k +: 8] ^ 8'h5a;
    end
    start_frame(dest, op);
    for (int i = 0; i < 56; i++) add_byte(byte_t'($random(seed)));
    arm_reply(op, 1'b0);
    send_frame();
    finish_frame(0, 0);
  endtask

  // compares ack bytes and pixels as they leave the DUT
  always @(negedge clk) begin
    if (!reset) begin
      if (out_eth_stream[9] && !out_frm_d) ack_frames++;
      out_frm_d = out_eth_stream[9];
      if (out_eth_stream[8]) begin
        if (wr_armed) abort_run("ack byte sent before eth_wr_done");
        else if (ack_idx >= exp_ack_len) abort_run("ack byte where none was expected");
        else begin
          check_byte($sformatf("ack byte %0d", ack_idx),
                     exp_ack[ACK_BITS-1-8*ack_idx -: 8], out_eth_stream[7:0]);
          ack_idx++;
        end
      end
      if (eth_wr_stb) begin
        if (pix_idx >= exp_npix) abort_run("pixel strobe beyond num pixels");
        else begin
          check_pixel($sformatf("pixel %0d", pix_idx), exp_pix[pix_idx], eth_wr_pix);
          pix_idx++;
        end
      end
      if (eth_wr_go) begin
        go_cnt++;
        check_word("go start x", m_wx, eth_wr_start_x);
        check_word("go line", m_wl, eth_wr_line);
        check_word("go num pixels", m_wn, eth_wr_num_pixels);
      end
      if (ctrl_strb) strb_cnt++;
    end
  end

  // pixel writer, done a few cycles after the last strobe
  initial begin
    forever begin
      @(posedge clk);
      if (wr_armed && pix_idx == exp_npix) begin
        repeat (3) @(posedge clk);
        #1 eth_wr_done = 1'b1;
        @(posedge clk);
        #1 eth_wr_done = 1'b0;
        wr_armed = 1'b0;
      end
    end
  end

  // drawn on the edge, driven 1 ns later
  initial begin
    logic tick;
    forever begin
      @(posedge clk);
      tick = ($unsigned($random(seed)) % 8) < 5;
      #1 out_tick = tick;
    end
  end

  initial begin
    #(NUM_FRAMES * FRAME_NS);
    abort_run("watchdog expired before all frames were handled");
  end

  // stopped with no verdict, e.g. by an assertion
  final begin
    if (!passed && !fail_shown) $display("=== FAIL ===");
  end

  initial begin
    int kind;
    reset         = 1'b1;
    out_tick      = 1'b0;
    eth_wr_done   = 1'b0;
    in_eth_stream = '0;
    temperature   = '0;
    v_vccint      = '0;
    v_vccaux      = '0;
    buttons       = '0;
    user_status   = '0;
    passed        = 1'b0;
    fail_shown    = 1'b0;
    out_frm_d     = 1'b0;
    wr_armed      = 1'b0;
    arm_reply(OP_CONTROL, 1'b0);
    ack_frames = 0;
    go_cnt     = 0;
    strb_cnt   = 0;
    {m_en, m_sx, m_sy, m_wx, m_wl, m_wn, m_uctl, m_uen} = '0;
    m_coeff = '0;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    if (eth_busy || ctrl_strb || eth_wr_go || eth_wr_stb || out_eth_stream[9:8] != 2'b00)
      abort_run("outputs not low after reset");
    check_regs();
    run_control();
    run_status();
    run_write();
    run_user();
    run_drop(1'b0);
    run_drop(1'b1);
    // random mix, each after eth_busy has fallen
    for (int i = 0; i < 20; i++) begin
      kind = $unsigned($random(seed)) % 6;
      case (kind)
        0: run_control();
        1: run_status();
        2: run_write();
        3: run_user();
        4: run_drop(1'b0);
        default: run_drop(1'b1);
      endcase
    end
    passed = 1'b1;
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- hdl/ack_framer.sv
`timescale 1ns/1ns

module ack_framer import pkt_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         out_tick,
  input  logic         load,
  input  opcode_t      opcode,
  input  word_t        temperature,
  input  word_t        v_vccint,
  input  word_t        v_vccaux,
  input  byte_t        buttons,
  input  logic [127:0] user_status,
  output logic [9:0]   out_eth_stream,
  output logic         done
);

  // reply bytes, next one on top
  logic [ACK_BITS-1:0] shift_q;
  // bytes still to send
  pos_t                left;
  // holds frame high between ticks and one cycle past the end
  logic                frm_q;
  logic                send;

  assign send = out_tick && (left != '0);

  // frame, valid, data
  assign out_eth_stream = {frm_q | send, send, shift_q[ACK_BITS-1 -: 8]};

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q <= '0;
      left    <= '0;
      frm_q   <= 1'b0;
      done    <= 1'b0;
    end else begin
      // pulse in the cycle after the last byte
      done <= send && (left == 11'd1);
      if (load) begin
        // status fields sampled here, only sent for a status reply
        shift_q <= {SERVER_MAC, MY_MAC, opcode, FIRMWARE_VERSION, BOARD_TYPE,
                    temperature, v_vccint, v_vccaux, buttons, user_status};
        left    <= (opcode == OP_STATUS) ? HDR_LEN + STATUS_LEN : HDR_LEN;
      end else if (send) begin
        shift_q <= shift_q << 8;
        left    <= left - 11'd1;
      end
      if (send) begin
        frm_q <= 1'b1;
      end else if (left == '0) begin
        frm_q <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/byte_counter.sv
`timescale 1ns/1ns

module byte_counter import pkt_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [9:0] in_eth_stream,
  rx_byte_if.source  rx
);

  // registered frame and clock-enable bits
  logic  frm_q;
  logic  cke_q;
  byte_t dat_q;
  // frame bit one clock later for the edge detect
  logic  frm_d;
  // valid bytes already seen in this frame
  pos_t  cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      frm_q <= 1'b0;
      cke_q <= 1'b0;
      dat_q <= '0;
      frm_d <= 1'b0;
      cnt   <= '0;
    end else begin
      frm_q <= in_eth_stream[9];
      cke_q <= in_eth_stream[8];
      dat_q <= in_eth_stream[7:0];
      frm_d <= frm_q;
      // restart between frames, hold at the top on long frames
      if (!frm_q) begin
        cnt <= '0;
      end else if (rx.valid && cnt != POS_MAX) begin
        cnt <= cnt + 11'd1;
      end
    end
  end

  assign rx.valid = frm_q & cke_q;
  assign rx.data  = dat_q;
  assign rx.pos   = cnt;
  // nothing counted yet means this is byte 0
  assign rx.start = rx.valid & (cnt == '0);
  // falling edge of the frame bit
  assign rx.done  = frm_d & ~frm_q;

endmodule

//--- hdl/field_capture.sv
`timescale 1ns/1ns

module field_capture import pkt_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  rx_byte_if.sink rx,
  input  opcode_t opcode,
  input  logic    wr_active,
  input  logic    ctrl_strb,
  input  logic    user_load,
  output word_t   ctrl_enables,
  output word_t   img_size_x,
  output word_t   img_size_y,
  output coeff_t  ctrl_coeff,
  output word_t   eth_wr_start_x,
  output word_t   eth_wr_line,
  output word_t   eth_wr_num_pixels,
  output logic    eth_wr_go,
  output logic    eth_wr_stb,
  output pixel_t  eth_wr_pix,
  output byte_t   user_ctrl_en,
  output word_t   user_ctrl
);

  // payload index and in-range byte strobe
  pos_t        pidx;
  logic        pbyte;
  // staged control and user fields
  word_t       en_s, sx_s, sy_s;
  coeff_t      coeff_s;
  byte_t       uen_s;
  word_t       uctl_s;
  // committed copies
  word_t       en_q, sx_q, sy_q;
  coeff_t      coeff_q;
  byte_t       uen_q;
  word_t       uctl_q;
  // pixel assembly, one-hot byte phase
  logic [2:0]  phase;
  logic [15:0] pix_part;
  word_t       pix_cnt;

  assign pidx  = rx.pos - HDR_LEN;
  assign pbyte = rx.valid && (rx.pos >= HDR_LEN) && (pidx < MAX_PAYLOAD);

  always_ff @(posedge clk) begin
    if (reset) begin
      en_s    <= '0;
      sx_s    <= '0;
      sy_s    <= '0;
      coeff_s <= '0;
      uen_s   <= '0;
      uctl_s  <= '0;
    end else if (pbyte) begin
      // high byte arrives first, shift left
      if (opcode == OP_CONTROL) begin
        if (pidx < F2_OFS) en_s <= {en_s[7:0], rx.data};
        else if (pidx < F3_OFS) sx_s <= {sx_s[7:0], rx.data};
        else if (pidx < BLK_OFS) sy_s <= {sy_s[7:0], rx.data};
        else coeff_s <= {coeff_s[391:0], rx.data};
      end
      if (opcode == OP_USER_CONTROL) begin
        if (pidx < USER_CTL_OFS) uen_s <= rx.data;
        else if (pidx < USER_END) uctl_s <= {uctl_s[7:0], rx.data};
      end
    end
  end

  // commit only on the strobe, dropped frames leave these alone
  always_ff @(posedge clk) begin
    if (reset) begin
      en_q    <= '0;
      sx_q    <= '0;
      sy_q    <= '0;
      coeff_q <= '0;
      uen_q   <= '0;
      uctl_q  <= '0;
    end else begin
      if (ctrl_strb) begin
        en_q    <= en_s;
        sx_q    <= sx_s;
        sy_q    <= sy_s;
        coeff_q <= coeff_s;
      end
      if (user_load) begin
        uen_q  <= uen_s;
        uctl_q <= uctl_s;
      end
    end
  end

  // new values already visible in the strobe cycle
  assign ctrl_enables = ctrl_strb ? en_s : en_q;
  assign img_size_x   = ctrl_strb ? sx_s : sx_q;
  assign img_size_y   = ctrl_strb ? sy_s : sy_q;
  assign ctrl_coeff   = ctrl_strb ? coeff_s : coeff_q;
  assign user_ctrl_en = user_load ? uen_s : uen_q;
  assign user_ctrl    = user_load ? uctl_s : uctl_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      eth_wr_start_x    <= '0;
      eth_wr_line       <= '0;
      eth_wr_num_pixels <= '0;
      eth_wr_go         <= 1'b0;
      eth_wr_stb        <= 1'b0;
      eth_wr_pix        <= '0;
      phase             <= 3'b001;
      pix_part          <= '0;
      pix_cnt           <= '0;
    end else begin
      eth_wr_go  <= pbyte && wr_active && (pidx == BLK_OFS - 11'd1);
      eth_wr_stb <= 1'b0;
      if (pbyte && wr_active) begin
        if (pidx < F2_OFS) begin
          eth_wr_start_x <= {eth_wr_start_x[7:0], rx.data};
        end else if (pidx < F3_OFS) begin
          eth_wr_line <= {eth_wr_line[7:0], rx.data};
        end else if (pidx < BLK_OFS) begin
          eth_wr_num_pixels <= {eth_wr_num_pixels[7:0], rx.data};
          // pixel stream starts with the next byte
          phase   <= 3'b001;
          pix_cnt <= '0;
        end else begin
          pix_part <= {pix_part[7:0], rx.data};
          phase    <= {phase[1:0], phase[2]};
          // third byte completes the pixel, no strobes past the count
          if (phase[2] && pix_cnt < eth_wr_num_pixels) begin
            eth_wr_pix <= {pix_part, rx.data};
            eth_wr_stb <= 1'b1;
            pix_cnt    <= pix_cnt + 16'd1;
          end
        end
      end
    end
  end

endmodule

//--- hdl/packet_engine.sv
`timescale 1ns/1ns

module packet_engine import pkt_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         out_tick,
  input  logic         eth_wr_done,
  input  logic [9:0]   in_eth_stream,
  input  word_t        temperature,
  input  word_t        v_vccint,
  input  word_t        v_vccaux,
  input  byte_t        buttons,
  input  logic [127:0] user_status,
  output logic [9:0]   out_eth_stream,
  output logic         eth_busy,
  output logic         ctrl_strb,
  output word_t        ctrl_enables,
  output word_t        img_size_x,
  output word_t        img_size_y,
  output coeff_t       ctrl_coeff,
  output logic         eth_wr_go,
  output logic         eth_wr_stb,
  output word_t        eth_wr_start_x,
  output word_t        eth_wr_line,
  output word_t        eth_wr_num_pixels,
  output pixel_t       eth_wr_pix,
  output byte_t        user_ctrl_en,
  output word_t        user_ctrl
);

  // fsm to framer and capture
  logic    ack_load;
  logic    ack_done;
  logic    user_load;
  logic    wr_active;
  opcode_t ack_opcode;

  // received bytes with position, one clock behind the port
  rx_byte_if rx ();

  byte_counter u_byte_counter (
    .clk           (clk),
    .reset         (reset),
    .in_eth_stream (in_eth_stream),
    .rx            (rx.source)
  );

  pkt_fsm u_pkt_fsm (
    .clk         (clk),
    .reset       (reset),
    .rx          (rx.sink),
    .eth_wr_done (eth_wr_done),
    .ack_done    (ack_done),
    .eth_busy    (eth_busy),
    .ctrl_strb   (ctrl_strb),
    .user_load   (user_load),
    .ack_load    (ack_load),
    .ack_opcode  (ack_opcode),
    .wr_active   (wr_active)
  );

  field_capture u_field_capture (
    .clk               (clk),
    .reset             (reset),
    .rx                (rx.sink),
    .opcode            (ack_opcode),
    .wr_active         (wr_active),
    .ctrl_strb         (ctrl_strb),
    .user_load         (user_load),
    .ctrl_enables      (ctrl_enables),
    .img_size_x        (img_size_x),
    .img_size_y        (img_size_y),
    .ctrl_coeff        (ctrl_coeff),
    .eth_wr_start_x    (eth_wr_start_x),
    .eth_wr_line       (eth_wr_line),
    .eth_wr_num_pixels (eth_wr_num_pixels),
    .eth_wr_go         (eth_wr_go),
    .eth_wr_stb        (eth_wr_stb),
    .eth_wr_pix        (eth_wr_pix),
    .user_ctrl_en      (user_ctrl_en),
    .user_ctrl         (user_ctrl)
  );

  ack_framer u_ack_framer (
    .clk            (clk),
    .reset          (reset),
    .out_tick       (out_tick),
    .load           (ack_load),
    .opcode         (ack_opcode),
    .temperature    (temperature),
    .v_vccint       (v_vccint),
    .v_vccaux       (v_vccaux),
    .buttons        (buttons),
    .user_status    (user_status),
    .out_eth_stream (out_eth_stream),
    .done           (ack_done)
  );

endmodule

//--- hdl/pkt_fsm.sv
`timescale 1ns/1ns

module pkt_fsm import pkt_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  rx_byte_if.sink rx,
  input  logic    eth_wr_done,
  input  logic    ack_done,
  output logic    eth_busy,
  output logic    ctrl_strb,
  output logic    user_load,
  output logic    ack_load,
  output opcode_t ack_opcode,
  output logic    wr_active
);

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    PAYLOAD,
    DROP,
    WAIT_WR,
    ACK
  } state_t;

  state_t state;
  // ack load still owed after entering ACK
  logic   ack_pend;
  // writer may finish before the frame does
  logic   wr_done_seen;
  // expected destination byte at the current position
  byte_t  mac_byte;
  logic   op_known;

  assign mac_byte = byte_t'(MY_MAC >> (8 * (DEST_LEN - 1 - rx.pos)));
  assign op_known = rx.data inside {OP_CONTROL, OP_STATUS, OP_WRITE, OP_USER_CONTROL};
  // anything but idle blocks new frames
  assign eth_busy = (state != IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= IDLE;
      ctrl_strb    <= 1'b0;
      user_load    <= 1'b0;
      ack_load     <= 1'b0;
      ack_opcode   <= '0;
      wr_active    <= 1'b0;
      ack_pend     <= 1'b0;
      wr_done_seen <= 1'b0;
    end else begin
      // single cycle pulses
      ctrl_strb <= 1'b0;
      user_load <= 1'b0;
      ack_load  <= 1'b0;
      case (state)
        IDLE: begin
          if (rx.start) begin
            wr_done_seen <= 1'b0;
            state        <= (rx.data == mac_byte) ? HEADER : DROP;
          end
        end
        HEADER: begin
          // frame too short to hold an opcode
          if (rx.done) begin
            state <= IDLE;
          end else if (rx.valid) begin
            if (rx.pos < DEST_LEN && rx.data != mac_byte) begin
              state <= DROP;
            end else if (rx.pos == OPCODE_POS) begin
              ack_opcode <= rx.data;
              wr_active  <= op_known && (rx.data == OP_WRITE);
              state      <= op_known ? PAYLOAD : DROP;
            end
          end
        end
        PAYLOAD: begin
          if (eth_wr_done) begin
            wr_done_seen <= 1'b1;
          end
          if (rx.done) begin
            wr_active <= 1'b0;
            if (ack_opcode == OP_WRITE) begin
              state <= WAIT_WR;
            end else begin
              ctrl_strb <= (ack_opcode == OP_CONTROL);
              user_load <= (ack_opcode == OP_USER_CONTROL);
              ack_pend  <= 1'b1;
              state     <= ACK;
            end
          end
        end
        DROP: begin
          if (rx.done) begin
            state <= IDLE;
          end
        end
        WAIT_WR: begin
          if (eth_wr_done || wr_done_seen) begin
            ack_load <= 1'b1;
            state    <= ACK;
          end
        end
        ACK: begin
          // one load the cycle after the action
          ack_load <= ack_pend;
          ack_pend <= 1'b0;
          if (ack_done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- hdl/pkt_pkg.sv
package pkt_pkg;

  // stream byte and multi-byte field types
  typedef logic [7:0]   byte_t;
  typedef logic [15:0]  word_t;
  typedef logic [23:0]  pixel_t;
  typedef logic [47:0]  mac_t;
  typedef logic [399:0] coeff_t;
  // byte position inside a received frame
  typedef logic [10:0]  pos_t;
  typedef logic [7:0]   opcode_t;

  // opcodes handled by the engine
  localparam opcode_t OP_CONTROL      = 8'h01;
  localparam opcode_t OP_STATUS       = 8'h02;
  localparam opcode_t OP_WRITE        = 8'h03;
  localparam opcode_t OP_USER_CONTROL = 8'h05;

  // host and board addresses
  localparam mac_t SERVER_MAC = 48'h00_10_8b_f1_f5_7d;
  localparam mac_t MY_MAC     = 48'h00_10_8b_f1_f5_7e;

  // board identity sent in the status reply
  localparam byte_t       FIRMWARE_VERSION = 8'hff;
  localparam logic [39:0] BOARD_TYPE       = 40'h53_50_36_30_31;

  // frame geometry, in bytes
  localparam pos_t MAX_PAYLOAD = 11'd56;
  localparam pos_t HDR_LEN     = 11'd13;
  localparam pos_t STATUS_LEN  = 11'd29;
  localparam pos_t DEST_LEN    = 11'd6;
  localparam pos_t OPCODE_POS  = HDR_LEN - 11'd1;
  // byte counter stops here
  localparam pos_t POS_MAX     = '1;

  // payload offsets shared by control and write frames
  localparam pos_t F2_OFS  = 11'd2;
  localparam pos_t F3_OFS  = 11'd4;
  // coefficients or pixels start after three words
  localparam pos_t BLK_OFS = 11'd6;

  // user control payload layout
  localparam pos_t USER_CTL_OFS = 11'd1;
  localparam pos_t USER_END     = 11'd3;

  // longest acknowledge frame, in bits
  localparam int ACK_BITS = 8 * (HDR_LEN + STATUS_LEN);

endpackage

//--- hdl/rx_byte_if.sv
`timescale 1ns/1ns

interface rx_byte_if import pkt_pkg::*; ();

  // byte strobe, only inside a frame
  logic  valid;
  byte_t data;
  // position of data within the frame
  pos_t  pos;
  // first valid byte of a frame
  logic  start;
  // cycle after the frame bit dropped
  logic  done;

  modport source (
    output valid,
    output data,
    output pos,
    output start,
    output done
  );

  modport sink (
    input valid,
    input data,
    input pos,
    input start,
    input done
  );

endinterface

//--- list.f
hdl/pkt_pkg.sv
hdl/rx_byte_if.sv
hdl/byte_counter.sv
hdl/pkt_fsm.sv
hdl/field_capture.sv
hdl/ack_framer.sv
hdl/packet_engine.sv
bench/packet_engine_checker.sv
bench/packet_engine_tb.sv
